// File: rtl/cart_pkg.sv
package cart_pkg;

	////////////////////////////////////////////////////////////
	// Stream and memory widths

	typedef logic [24:0] ioctl_addr_t;    // Byte address from the host
	typedef logic [15:0] ioctl_word_t;
	typedef logic [23:0] rom_addr_t;      // Word address to SDRAM and DDR3
	typedef logic [7:0]  ioctl_index_t;   // File-type index
	typedef logic [63:0] cart_id_t;       // Eight ASCII characters
	typedef logic [1:0]  region_t;

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// Search order per priority setting, slot 0 first
	typedef region_t [0:2] region_order_t;
	localparam region_order_t PRIO_ORDER [4] = '{
		{REGION_US, REGION_EU, REGION_JP},
		{REGION_EU, REGION_US, REGION_JP},
		{REGION_US, REGION_JP, REGION_EU},
		{REGION_JP, REGION_US, REGION_EU}
	};

	localparam logic [1:0] AUTO_FILE_EXT = 2'd0;
	localparam logic [1:0] AUTO_HEADER   = 2'd1;    // 2 and 3 disable auto region

	////////////////////////////////////////////////////////////
	// Cartridge header byte addresses

	localparam ioctl_addr_t HDR_ID_FIRST = 25'h182;
	localparam ioctl_addr_t HDR_ID_LAST  = 25'h18A;
	localparam ioctl_addr_t HDR_ID_DONE  = 25'h18C;
	localparam ioctl_addr_t HDR_REGION_A = 25'h1F0;
	localparam ioctl_addr_t HDR_REGION_B = 25'h1F2;
	localparam ioctl_addr_t HDR_END      = 25'h200;

	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

	////////////////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		logic         download;
		logic         wr;
		ioctl_addr_t  addr;
		ioctl_word_t  data;
		ioctl_index_t index;
	} ioctl_bus_t;

	typedef struct packed {
		logic [1:0] auto_mode;
		logic [1:0] prio;
	} region_cfg_t;

	typedef struct packed {
		logic hdr_j;
		logic hdr_u;
		logic hdr_e;
	} hdr_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	typedef struct packed {
		cart_id_t id;
		quirk_t   quirk;
		gun_cfg_t gun;
	} quirk_entry_t;

	localparam gun_cfg_t GUN_DEFAULT = '{gun_type: 1'b0, sensor_delay: GUN_DELAY_DEFAULT};

	localparam int QUIRK_COUNT = 12;
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{"T-081276", '{sram: 1'b1, default: 1'b0},   GUN_DEFAULT},   // NFL QB Club
		'{"T-81406 ", '{sram: 1'b1, default: 1'b0},   GUN_DEFAULT},   // NBA Jam TE
		'{"MK-1215 ", '{eeprom: 1'b1, default: 1'b0}, GUN_DEFAULT},
		'{"G-4060  ", '{eeprom: 1'b1, default: 1'b0}, GUN_DEFAULT},   // Wonder Boy
		'{"T-113016", '{noram: 1'b1, default: 1'b0},  GUN_DEFAULT},   // Puggsy
		'{"T-89016 ", '{fifo: 1'b1, default: 1'b0},   GUN_DEFAULT},   // Clue
		'{"T-574023", '{pier: 1'b1, default: 1'b0},   GUN_DEFAULT},
		'{"MK-1229 ", '{svp: 1'b1, default: 1'b0},    GUN_DEFAULT},   // Virtua Racing
		'{"T-35036 ", '{fmbusy: 1'b1, default: 1'b0}, GUN_DEFAULT},   // Hellfire US
		'{"T-68???-", '{schan: 1'b1, default: 1'b0},  GUN_DEFAULT},
		'{"T-95096-", '0, '{gun_type: 1'b1, sensor_delay: 8'd52}},    // Lethal Enforcers
		'{"MK-1533 ", '0, '{gun_type: 1'b0, sensor_delay: 8'd100}}    // Body Count
	};

	// Host words arrive little endian, the 68k side wants big endian
	function automatic ioctl_word_t swap_bytes(input ioctl_word_t w);
		return {w[7:0], w[15:8]};
	endfunction

endpackage

// File: rtl/header_decoder.sv
`timescale 1ns/1ps

module header_decoder import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  ioctl_bus_t ioctl,
	output hdr_flags_t flags,
	output logic       hdr_ready,
	output cart_id_t   cart_id,
	output logic       id_done,
	output logic       dl_start
);

	logic        dl_q;
	logic        dl_end;
	logic        hdr_wr;        // Host write inside a download
	ioctl_word_t word_sw;
	hdr_flags_t  letter_hits;

	// One region letter to its flag
	function automatic hdr_flags_t classify(input logic [7:0] c);
		hdr_flags_t f;
		f = '0;
		if (c == "J")
			f.hdr_j = 1'b1;
		else if (c == "U")
			f.hdr_u = 1'b1;
		else if (c >= "0" && c <= "Z")
			f.hdr_e = 1'b1;    // Anything else printable counts as EU
		return f;
	endfunction

	assign dl_start = ioctl.download & ~dl_q;
	assign dl_end   = ~ioctl.download & dl_q;
	assign hdr_wr   = ioctl.download & ioctl.wr;
	assign word_sw  = swap_bytes(ioctl.data);

	// Low byte of both region words, high byte of the first only
	always_comb begin
		letter_hits = '0;
		if (hdr_wr && (ioctl.addr == HDR_REGION_A || ioctl.addr == HDR_REGION_B))
			letter_hits = classify(ioctl.data[7:0]);
		if (hdr_wr && ioctl.addr == HDR_REGION_A)
			letter_hits = letter_hits | classify(ioctl.data[15:8]);
	end

	////////////////////////////////////////////////////////////
	// Download edges, region flags, header ready

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			flags     <= '0;
			hdr_ready <= 1'b0;
			id_done   <= 1'b0;
		end else begin
			dl_q    <= ioctl.download;
			id_done <= hdr_wr && ioctl.addr == HDR_ID_DONE;    // Starts the quirk lookup

			if (dl_start)
				flags <= '0;
			else
				flags <= flags | letter_hits;

			if (dl_end)
				hdr_ready <= 1'b0;
			else if (hdr_wr && ioctl.addr == HDR_END)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Product ID
	// The ID starts on the odd byte 0x183 so the end words carry one char

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl.addr)
				HDR_ID_FIRST:         cart_id[63:56] <= word_sw[7:0];
				HDR_ID_FIRST + 25'd2: cart_id[55:40] <= word_sw;
				HDR_ID_FIRST + 25'd4: cart_id[39:24] <= word_sw;
				HDR_ID_FIRST + 25'd6: cart_id[23:8]  <= word_sw;
				HDR_ID_LAST:          cart_id[7:0]   <= word_sw[15:8];
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/quirk_lookup.sv
`timescale 1ns/1ps

module quirk_lookup import cart_pkg::*; (
	input  logic     clk_sys,
	input  logic     RESET,
	input  cart_id_t cart_id,
	input  logic     id_done,
	input  logic     dl_start,
	output quirk_t   quirks,
	output gun_cfg_t gun
);

	quirk_t   hit_quirks;
	gun_cfg_t hit_gun;

	////////////////////////////////////////////////////////////
	// Table match
	// Table IDs are distinct so at most one entry hits

	always_comb begin
		hit_quirks = '0;
		hit_gun    = GUN_DEFAULT;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (cart_id == QUIRK_TABLE[i].id) begin
				hit_quirks = QUIRK_TABLE[i].quirk;
				hit_gun    = QUIRK_TABLE[i].gun;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Result registers

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks <= '0;
			gun    <= GUN_DEFAULT;
		end else if (dl_start) begin
			quirks <= '0;            // New image clears the old game
			gun    <= GUN_DEFAULT;
		end else if (id_done) begin
			quirks <= quirks | hit_quirks;
			gun    <= hit_gun;       // Default when nothing matched
		end
	end

endmodule

// File: rtl/region_select.sv
`timescale 1ns/1ps

module region_select import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  hdr_flags_t  flags,
	input  logic        hdr_ready,
	input  ioctl_bus_t  ioctl,
	input  region_cfg_t cfg,
	output region_t     region_req,
	output logic        region_set
);

	logic          ready_q;
	logic          ready_rise;
	logic          ready_fall;
	region_order_t order;
	region_t       hdr_pick;

	// Was this region named in the header
	function automatic logic seen(input hdr_flags_t f, input region_t r);
		case (r)
			REGION_JP: return f.hdr_j;
			REGION_US: return f.hdr_u;
			REGION_EU: return f.hdr_e;
			default:   return 1'b0;
		endcase
	endfunction

	assign ready_rise = hdr_ready & ~ready_q;
	assign ready_fall = ~hdr_ready & ready_q;
	assign order      = PRIO_ORDER[cfg.prio];

	// Walk backwards so the earliest present slot wins
	always_comb begin
		hdr_pick = order[0];    // Fallback when no letter was seen
		for (int i = 2; i >= 0; i--) begin
			if (seen(flags, order[i]))
				hdr_pick = order[i];
		end
	end

	////////////////////////////////////////////////////////////
	// Region request

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (ready_rise) begin
				case (cfg.auto_mode)
					AUTO_HEADER: begin
						region_set <= 1'b1;
						region_req <= hdr_pick;
					end
					AUTO_FILE_EXT: begin
						region_set <= |ioctl.index;
						region_req <= ioctl.index[7:6];    // Region coded in index top bits
					end
					default: ;
				endcase
			end else if (ready_fall) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/rom_write_ctrl.sv
`timescale 1ns/1ps

module rom_write_ctrl import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_bus_t  ioctl,
	input  logic        sdram_ack,
	input  logic        ddram_ack,
	output logic        ioctl_wait,
	output logic        rom_wr,
	output rom_addr_t   rom_addr,
	output ioctl_word_t rom_data,
	output ioctl_addr_t rom_sz
);

	logic dl_q;
	logic host_wr;
	logic acked;       // Both memories caught up with rom_wr

	assign host_wr = ioctl.download & ioctl.wr;
	assign acked   = (sdram_ack == rom_wr) && (ddram_ack == rom_wr);

	////////////////////////////////////////////////////////////
	// Toggle request and host wait

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q       <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_q <= ioctl.download;
			if (host_wr) begin
				rom_wr     <= ~rom_wr;    // One toggle per word
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && acked) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word to both memories and the final size
	always_ff @(posedge clk_sys) begin
		if (host_wr) begin
			rom_addr <= ioctl.addr[24:1];
			rom_data <= swap_bytes(ioctl.data);
		end
		if (dl_q && !ioctl.download)
			rom_sz <= ioctl.addr;     // Host leaves addr on the last word
	end

endmodule

// File: rtl/cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_bus_t  ioctl,
	input  region_cfg_t region_cfg,
	input  logic        sdram_ack,
	input  logic        ddram_ack,
	output logic        ioctl_wait,
	output logic        rom_wr,
	output rom_addr_t   rom_addr,
	output ioctl_word_t rom_data,
	output ioctl_addr_t rom_sz,
	output region_t     region_req,
	output logic        region_set,
	output quirk_t      quirks,
	output gun_cfg_t    gun
);

	hdr_flags_t hdr_flags;
	logic       hdr_ready;
	cart_id_t   cart_id;
	logic       id_done;     // ID complete, one cycle pulse
	logic       dl_start;

	////////////////////////////////////////////////////////////
	// Header path

	header_decoder header_decoder (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.ioctl     (ioctl),
		.flags     (hdr_flags),
		.hdr_ready (hdr_ready),
		.cart_id   (cart_id),
		.id_done   (id_done),
		.dl_start  (dl_start)
	);

	quirk_lookup quirk_lookup (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.cart_id  (cart_id),
		.id_done  (id_done),
		.dl_start (dl_start),
		.quirks   (quirks),
		.gun      (gun)
	);

	region_select region_select (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.flags      (hdr_flags),
		.hdr_ready  (hdr_ready),
		.ioctl      (ioctl),
		.cfg        (region_cfg),
		.region_req (region_req),
		.region_set (region_set)
	);

	////////////////////////////////////////////////////////////
	// ROM write path

	rom_write_ctrl rom_write_ctrl (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.sdram_ack  (sdram_ack),
		.ddram_ack  (ddram_ack),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_sz     (rom_sz)
	);

endmodule

// File: bench/tb_cart_tasks.svh
`ifndef TB_CART_TASKS_SVH
`define TB_CART_TASKS_SVH

int          mismatch_count = 0;
int          failure_count  = 0;
logic [15:0] lfsr_state     = 16'd15;
logic [7:0]  image [0:'h20F];    // Cartridge bytes in host byte order

////////////////////////////////////////////////////////////
// Error counting

task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
	assert (got === exp) else begin
		mismatch_count++;
		$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic note_failure(input string what);
	failure_count++;
	$display("Failure at %0d ns: %s", $time, what);
endtask

// Fibonacci LFSR with taps 16 14 13 11
function automatic int lfsr_take(input int n);
	int   v;
	logic fb;
	v = 0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		v = {v[30:0], fb};
	end
	return v;
endfunction

// Fill pattern with the product ID at 0x183 and region letters at 0x1F0
task automatic build_image(input cart_id_t id, input string letters);
	for (int a = 0; a < 'h210; a++)
		image[a] = 8'(a) ^ 8'(a >> 3) ^ 8'h3C;
	for (int k = 0; k < 8; k++)
		image['h183 + k] = id[63 - 8 * k -: 8];
	for (int k = 0; k < 4; k++)
		image['h1F0 + k] = " ";
	for (int k = 0; k < letters.len(); k++)
		image['h1F0 + k] = letters[k];
endtask

task automatic wait_host_ready();
	int cycles;
	cycles = 0;
	while (ioctl_wait && cycles < 40) begin
		@(negedge clk_sys);
		cycles++;
		assert (ioctl_wait || (sdram_ack == rom_wr && ddram_ack == rom_wr)) else
			note_failure("ioctl_wait fell before both acks matched rom_wr");
	end
	assert (!ioctl_wait) else
		note_failure("ioctl_wait still high after 40 cycles");
endtask

`endif

// File: bench/tb_cart_loader.sv
`timescale 1ns/1ps

module tb_cart_loader import cart_pkg::*; ();

	logic        clk_sys;
	logic        RESET;
	ioctl_bus_t  ioctl;
	region_cfg_t region_cfg;
	logic        sdram_ack = 1'b0;
	logic        ddram_ack = 1'b0;
	logic        ioctl_wait;
	logic        rom_wr;
	rom_addr_t   rom_addr;
	ioctl_word_t rom_data;
	ioctl_addr_t rom_sz;
	region_t     region_req;
	logic        region_set;
	quirk_t      quirks;
	gun_cfg_t    gun;

	logic  wr_seen = 1'b0;    // Last rom_wr level the memories saw
	int    sd_left = -1;
	int    dd_left = -1;
	string letter_sets [4];

	`include "tb_cart_tasks.svh"

	cart_loader_top cart_loader_top_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.region_cfg (region_cfg),
		.sdram_ack  (sdram_ack),
		.ddram_ack  (ddram_ack),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_sz     (rom_sz),
		.region_req (region_req),
		.region_set (region_set),
		.quirks     (quirks),
		.gun        (gun)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Memory model echoes rom_wr on each ack after 0 to 7 cycles
	always @(negedge clk_sys) begin
		if (rom_wr != wr_seen) begin
			wr_seen = rom_wr;
			sd_left = lfsr_take(3);
			dd_left = lfsr_take(3);
		end
		if (sd_left == 0)
			sdram_ack <= wr_seen;
		if (dd_left == 0)
			ddram_ack <= wr_seen;
		if (sd_left >= 0)
			sd_left--;
		if (dd_left >= 0)
			dd_left--;
	end

	function automatic region_t letter_region(input byte c);
		if (c == "J")
			return REGION_JP;
		else if (c == "U")
			return REGION_US;
		return REGION_EU;
	endfunction

	function automatic region_t expected_region(input logic [1:0] prio, input string letters);
		string   order;
		region_t pick;
		logic    found;
		case (prio)
			2'd0:    order = "UEJ";
			2'd1:    order = "EUJ";
			2'd2:    order = "UJE";
			default: order = "JUE";
		endcase
		pick  = letter_region(order[0]);    // No letter seen
		found = 1'b0;
		for (int i = 0; i < 3; i++)
			for (int k = 0; k < letters.len(); k++)
				if (!found && order[i] == letters[k]) begin
					pick  = letter_region(order[i]);
					found = 1'b1;
				end
		return pick;
	endfunction

	task automatic write_word(input ioctl_addr_t a, input logic [7:0] lo, input logic [7:0] hi);
		logic wr_expect;
		wr_expect  = ~rom_wr;
		ioctl.addr = a;
		ioctl.data = {hi, lo};
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		check_value("rom_wr", 64'(rom_wr), 64'(wr_expect));
		check_value("rom_addr", 64'(rom_addr), 64'(a[24:1]));
		check_value("rom_data", 64'(rom_data), 64'({lo, hi}));    // Big endian
		check_value("ioctl_wait", 64'(ioctl_wait), 64'd1);
		wait_host_ready();
		check_value("rom_wr", 64'(rom_wr), 64'(wr_expect));    // Single toggle per word
	endtask

	task automatic send_image(input int first);
		for (int a = first; a < 'h210; a += 2)
			write_word(ioctl_addr_t'(a), image[a], image[a + 1]);
	endtask

	task automatic start_download(input logic [1:0] mode, input logic [1:0] prio,
			input ioctl_index_t index);
		region_cfg.auto_mode = mode;
		region_cfg.prio      = prio;
		ioctl.index          = index;
		ioctl.download       = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic finish_download();
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("rom_sz", 64'(rom_sz), 64'h20E);
		check_value("region_set", 64'(region_set), 64'd0);
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		quirk_t   svp_only;
		gun_cfg_t gun_default;
		gun_cfg_t gun_enforcer;
		svp_only     = '0;
		svp_only.svp = 1'b1;
		gun_default  = '{gun_type: 1'b0, sensor_delay: GUN_DELAY_DEFAULT};
		gun_enforcer = '{gun_type: 1'b1, sensor_delay: 8'd52};
		letter_sets[0] = "J";
		letter_sets[1] = "UE";
		letter_sets[2] = "JU";
		letter_sets[3] = "";
		RESET      = 1'b1;
		ioctl      = '0;
		region_cfg = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		check_value("ioctl_wait", 64'(ioctl_wait), 64'd0);
		check_value("rom_wr", 64'(rom_wr), 64'd0);
		check_value("region_set", 64'(region_set), 64'd0);
		check_value("gun", 64'(gun), 64'(gun_default));

		// Header mode over every priority and letter set
		for (int p = 0; p < 4; p++)
			for (int s = 0; s < 4; s++) begin
				build_image("GM-00001", letter_sets[s]);
				start_download(AUTO_HEADER, 2'(p), 8'h00);
				send_image(0);
				check_value("region_set", 64'(region_set), 64'd1);
				check_value("region_req", 64'(region_req),
					64'(expected_region(2'(p), letter_sets[s])));
				finish_download();
			end

		// File extension mode
		build_image("GM-00001", "JU");
		start_download(AUTO_FILE_EXT, 2'd0, 8'h80);
		send_image(0);
		check_value("region_set", 64'(region_set), 64'd1);
		check_value("region_req", 64'(region_req), 64'(REGION_EU));
		finish_download();
		start_download(AUTO_FILE_EXT, 2'd0, 8'h00);
		send_image(0);
		check_value("region_set", 64'(region_set), 64'd0);
		finish_download();

		// Quirk table hits and an unknown ID
		build_image("MK-1229 ", "U");
		start_download(AUTO_HEADER, 2'd0, 8'h00);
		send_image(0);
		check_value("quirks", 64'(quirks), 64'(svp_only));
		check_value("gun", 64'(gun), 64'(gun_default));
		finish_download();
		build_image("T-95096-", "U");
		start_download(AUTO_HEADER, 2'd0, 8'h00);
		write_word(25'h0, image[0], image[1]);
		check_value("quirks", 64'(quirks), 64'd0);    // Old flags gone
		send_image(2);
		check_value("gun", 64'(gun), 64'(gun_enforcer));
		finish_download();
		build_image("GM-00001", "U");
		start_download(AUTO_HEADER, 2'd0, 8'h00);
		send_image(0);
		check_value("gun", 64'(gun), 64'(gun_default));
		check_value("quirks", 64'(quirks), 64'd0);
		finish_download();

		$display("Closing counts: %0d mismatches, %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: cart_loader_top.f
+incdir+bench
rtl/cart_pkg.sv
rtl/header_decoder.sv
rtl/quirk_lookup.sv
rtl/region_select.sv
rtl/rom_write_ctrl.sv
rtl/cart_loader_top.sv
bench/tb_cart_loader.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the cart loader testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_cart_loader -f cart_loader_top.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cart_loader)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1
